// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_axi_wr_mux
FILELIST  = project.f
BUILD     = obj_dir
LOG       = sim.log
RUN_ARGS  = +verilator+error+limit+1000

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: project.f
+incdir+rtl
rtl/axi_mux_pkg.sv
rtl/mux_aw_arbiter.sv
rtl/mux_w_route.sv
rtl/mux_b_route.sv
rtl/axi_wr_mux.sv
tests/axi_wr_mux_assert.sv
tests/tb_axi_wr_mux.sv

// File: rtl/axi_mux_defines.svh
// --------------------
// Build-time sizes of the AXI write multiplexer
// Included by the package and by each RTL file that sizes port arrays
// --------------------
`ifndef AXI_MUX_DEFINES_SVH
`define AXI_MUX_DEFINES_SVH

// Upstream port count and the index bits that select one port
`define AXI_MUX_NUM_PORTS   4
`define AXI_MUX_PORT_IDX_W  2

// Upstream ID width
`define AXI_MUX_SLV_ID_W    2
// Downstream ID carries the port index above the upstream ID
`define AXI_MUX_MST_ID_W    (`AXI_MUX_SLV_ID_W + `AXI_MUX_PORT_IDX_W)

// Payload widths
`define AXI_MUX_ADDR_W      16
`define AXI_MUX_DATA_W      16
`define AXI_MUX_LEN_W       8

// Open write bursts the W route can track
`define AXI_MUX_MAX_W_TRANS 4

`endif

// File: rtl/axi_mux_pkg.sv
// --------------------
// Shared types of the AXI write multiplexer
// Modules import it in their body and use scoped names in port lists
// --------------------
`include "axi_mux_defines.svh"

package axi_mux_pkg;

  // --------------------
  // Channel fields
  // --------------------
  typedef logic [`AXI_MUX_SLV_ID_W-1:0]   slv_id_t;
  // Upper bits hold the upstream port index
  typedef logic [`AXI_MUX_MST_ID_W-1:0]   mst_id_t;
  typedef logic [`AXI_MUX_ADDR_W-1:0]     addr_t;
  typedef logic [`AXI_MUX_DATA_W-1:0]     data_t;
  // Beats minus one
  typedef logic [`AXI_MUX_LEN_W-1:0]      len_t;
  typedef logic [1:0]                     resp_t;

  // --------------------
  // Port selection
  // --------------------
  typedef logic [`AXI_MUX_PORT_IDX_W-1:0] port_idx_t;
  // One bit per upstream port
  typedef logic [`AXI_MUX_NUM_PORTS-1:0]  port_mask_t;

  // AW issue state of the W route
  typedef enum logic {
    AW_FREE   = 1'b0,
    AW_LOCKED = 1'b1
  } aw_lock_e;

endpackage

// File: rtl/axi_wr_mux.sv
// --------------------
// Four-port AXI4 write path multiplexer
// Upstream masters connect on the slv_ ports, the shared slave on mst_
// --------------------
`timescale 1ns/1ns
`include "axi_mux_defines.svh"

module axi_wr_mux (
  input  logic                                          clk_i,
  input  logic                                          reset_i,
  // Upstream AW
  input  axi_mux_pkg::port_mask_t                       slv_aw_valid_i,
  output axi_mux_pkg::port_mask_t                       slv_aw_ready_o,
  input  axi_mux_pkg::slv_id_t [`AXI_MUX_NUM_PORTS-1:0] slv_aw_id_i,
  input  axi_mux_pkg::addr_t   [`AXI_MUX_NUM_PORTS-1:0] slv_aw_addr_i,
  input  axi_mux_pkg::len_t    [`AXI_MUX_NUM_PORTS-1:0] slv_aw_len_i,
  // Upstream W
  input  axi_mux_pkg::port_mask_t                       slv_w_valid_i,
  output axi_mux_pkg::port_mask_t                       slv_w_ready_o,
  input  axi_mux_pkg::data_t   [`AXI_MUX_NUM_PORTS-1:0] slv_w_data_i,
  input  axi_mux_pkg::port_mask_t                       slv_w_last_i,
  // Upstream B
  output axi_mux_pkg::port_mask_t                       slv_b_valid_o,
  input  axi_mux_pkg::port_mask_t                       slv_b_ready_i,
  output axi_mux_pkg::slv_id_t [`AXI_MUX_NUM_PORTS-1:0] slv_b_id_o,
  output axi_mux_pkg::resp_t   [`AXI_MUX_NUM_PORTS-1:0] slv_b_resp_o,
  // Downstream AW
  output logic                                          mst_aw_valid_o,
  input  logic                                          mst_aw_ready_i,
  output axi_mux_pkg::mst_id_t                          mst_aw_id_o,
  output axi_mux_pkg::addr_t                            mst_aw_addr_o,
  output axi_mux_pkg::len_t                             mst_aw_len_o,
  // Downstream W
  output logic                                          mst_w_valid_o,
  input  logic                                          mst_w_ready_i,
  output axi_mux_pkg::data_t                            mst_w_data_o,
  output logic                                          mst_w_last_o,
  // Downstream B
  input  logic                                          mst_b_valid_i,
  output logic                                          mst_b_ready_o,
  input  axi_mux_pkg::mst_id_t                          mst_b_id_i,
  input  axi_mux_pkg::resp_t                            mst_b_resp_i
);
  import axi_mux_pkg::*;

  // Arbitrated AW, ID already prepended
  logic    arb_valid;
  logic    arb_ready;
  mst_id_t arb_id;
  addr_t   arb_addr;
  len_t    arb_len;

  mux_aw_arbiter u_aw_arbiter (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .slv_aw_valid_i (slv_aw_valid_i),
    .slv_aw_id_i    (slv_aw_id_i),
    .slv_aw_addr_i  (slv_aw_addr_i),
    .slv_aw_len_i   (slv_aw_len_i),
    .arb_ready_i    (arb_ready),
    .slv_aw_ready_o (slv_aw_ready_o),
    .arb_valid_o    (arb_valid),
    .arb_id_o       (arb_id),
    .arb_addr_o     (arb_addr),
    .arb_len_o      (arb_len)
  );

  mux_w_route u_w_route (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .arb_valid_i    (arb_valid),
    .arb_id_i       (arb_id),
    .arb_addr_i     (arb_addr),
    .arb_len_i      (arb_len),
    .mst_aw_ready_i (mst_aw_ready_i),
    .slv_w_valid_i  (slv_w_valid_i),
    .slv_w_data_i   (slv_w_data_i),
    .slv_w_last_i   (slv_w_last_i),
    .mst_w_ready_i  (mst_w_ready_i),
    .arb_ready_o    (arb_ready),
    .mst_aw_valid_o (mst_aw_valid_o),
    .mst_aw_id_o    (mst_aw_id_o),
    .mst_aw_addr_o  (mst_aw_addr_o),
    .mst_aw_len_o   (mst_aw_len_o),
    .slv_w_ready_o  (slv_w_ready_o),
    .mst_w_valid_o  (mst_w_valid_o),
    .mst_w_data_o   (mst_w_data_o),
    .mst_w_last_o   (mst_w_last_o)
  );

  mux_b_route u_b_route (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .mst_b_valid_i (mst_b_valid_i),
    .mst_b_id_i    (mst_b_id_i),
    .mst_b_resp_i  (mst_b_resp_i),
    .slv_b_ready_i (slv_b_ready_i),
    .mst_b_ready_o (mst_b_ready_o),
    .slv_b_valid_o (slv_b_valid_o),
    .slv_b_id_o    (slv_b_id_o),
    .slv_b_resp_o  (slv_b_resp_o)
  );

endmodule

// File: rtl/mux_aw_arbiter.sv
// --------------------
// Round-robin arbiter for the AW channels of all upstream ports
// Holds the grant until accepted and prepends the port index to the ID
// --------------------
`timescale 1ns/1ns
`include "axi_mux_defines.svh"

module mux_aw_arbiter (
  input  logic                                          clk_i,
  input  logic                                          reset_i,
  input  axi_mux_pkg::port_mask_t                       slv_aw_valid_i,
  input  axi_mux_pkg::slv_id_t [`AXI_MUX_NUM_PORTS-1:0] slv_aw_id_i,
  input  axi_mux_pkg::addr_t   [`AXI_MUX_NUM_PORTS-1:0] slv_aw_addr_i,
  input  axi_mux_pkg::len_t    [`AXI_MUX_NUM_PORTS-1:0] slv_aw_len_i,
  input  logic                                          arb_ready_i,
  output axi_mux_pkg::port_mask_t                       slv_aw_ready_o,
  output logic                                          arb_valid_o,
  output axi_mux_pkg::mst_id_t                          arb_id_o,
  output axi_mux_pkg::addr_t                            arb_addr_o,
  output axi_mux_pkg::len_t                             arb_len_o
);
  import axi_mux_pkg::*;

  localparam int unsigned NUM_PORTS = `AXI_MUX_NUM_PORTS;

  // Port with highest priority in the next free arbitration
  port_idx_t rr_q;
  // Grant held while the offered AW waits
  logic      lock_q;
  port_idx_t lock_idx_q;

  port_idx_t rr_idx;
  logic      rr_found;
  port_idx_t sel;
  logic      arb_hs;

  // --------------------
  // Priority search
  // --------------------
  // First requesting port at or after the pointer, wrapping around
  always_comb begin
    rr_idx   = rr_q;
    rr_found = 1'b0;
    for (int i = 0; i < NUM_PORTS; i++) begin
      if (!rr_found && slv_aw_valid_i[port_idx_t'(rr_q + i)]) begin
        rr_idx   = port_idx_t'(rr_q + i);
        rr_found = 1'b1;
      end
    end
  end

  assign sel         = lock_q ? lock_idx_q : rr_idx;
  // Upstream valid stays high until accepted, so the locked port is still valid
  assign arb_valid_o = slv_aw_valid_i[sel];
  assign arb_hs      = arb_valid_o & arb_ready_i;

  // ID prepend and payload select
  assign arb_id_o   = {sel, slv_aw_id_i[sel]};
  assign arb_addr_o = slv_aw_addr_i[sel];
  assign arb_len_o  = slv_aw_len_i[sel];

  // Only the granted port sees the handshake
  always_comb begin
    slv_aw_ready_o      = '0;
    slv_aw_ready_o[sel] = arb_hs;
  end

  // --------------------
  // Pointer and lock-in
  // --------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rr_q       <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else begin
      if (arb_hs) begin
        // Move past the winner only once it is accepted
        rr_q   <= port_idx_t'(sel + 1'b1);
        lock_q <= 1'b0;
      end else if (arb_valid_o) begin
        lock_q     <= 1'b1;
        lock_idx_q <= sel;
      end
    end
  end

endmodule

// File: rtl/mux_b_route.sv
// --------------------
// B response return path
// A two-entry spill register decouples the downstream B, and the upper
// ID bits pick the upstream port that gets the response
// --------------------
`timescale 1ns/1ns
`include "axi_mux_defines.svh"

module mux_b_route (
  input  logic                                          clk_i,
  input  logic                                          reset_i,
  input  logic                                          mst_b_valid_i,
  input  axi_mux_pkg::mst_id_t                          mst_b_id_i,
  input  axi_mux_pkg::resp_t                            mst_b_resp_i,
  input  axi_mux_pkg::port_mask_t                       slv_b_ready_i,
  output logic                                          mst_b_ready_o,
  output axi_mux_pkg::port_mask_t                       slv_b_valid_o,
  output axi_mux_pkg::slv_id_t [`AXI_MUX_NUM_PORTS-1:0] slv_b_id_o,
  output axi_mux_pkg::resp_t   [`AXI_MUX_NUM_PORTS-1:0] slv_b_resp_o
);
  import axi_mux_pkg::*;

  // Entry A takes new responses, entry B keeps one stalled behind it
  logic    a_full_q, b_full_q;
  mst_id_t a_id_q, b_id_q;
  resp_t   a_resp_q, b_resp_q;
  logic    a_fill, a_drain, b_fill, b_drain;
  logic    a_full_d, b_full_d;
  // Registered ready, low through reset and one cycle after
  logic    b_ready_q;

  logic      out_valid, out_ready;
  mst_id_t   out_id;
  resp_t     out_resp;
  port_idx_t out_port;

  assign mst_b_ready_o = b_ready_q;
  assign a_fill   = mst_b_valid_i && mst_b_ready_o;
  assign a_drain  = a_full_q && !b_full_q;
  assign b_fill   = a_drain && !out_ready;
  assign b_drain  = b_full_q && out_ready;
  assign a_full_d = a_fill ? 1'b1 : (a_drain ? 1'b0 : a_full_q);
  assign b_full_d = b_fill ? 1'b1 : (b_drain ? 1'b0 : b_full_q);

  // B holds the older entry whenever it is full
  assign out_valid = a_full_q || b_full_q;
  assign out_id    = b_full_q ? b_id_q : a_id_q;
  assign out_resp  = b_full_q ? b_resp_q : a_resp_q;

  // --------------------
  // Upstream steering
  // --------------------
  assign out_port  = out_id[`AXI_MUX_MST_ID_W-1 -: `AXI_MUX_PORT_IDX_W];
  assign out_ready = slv_b_ready_i[out_port];

  always_comb begin
    slv_b_valid_o = '0;
    if (out_valid) begin
      slv_b_valid_o[out_port] = 1'b1;
    end
  end

  // Port bits stripped, id and resp seen by all ports
  assign slv_b_id_o   = {`AXI_MUX_NUM_PORTS{out_id[`AXI_MUX_SLV_ID_W-1:0]}};
  assign slv_b_resp_o = {`AXI_MUX_NUM_PORTS{out_resp}};

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      a_full_q  <= 1'b0;
      b_full_q  <= 1'b0;
      b_ready_q <= 1'b0;
    end else begin
      a_full_q  <= a_full_d;
      b_full_q  <= b_full_d;
      b_ready_q <= !(a_full_d && b_full_d);
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_fill) begin
      a_id_q   <= mst_b_id_i;
      a_resp_q <= mst_b_resp_i;
    end
    if (b_fill) begin
      b_id_q   <= a_id_q;
      b_resp_q <= a_resp_q;
    end
  end

endmodule

// File: rtl/mux_w_route.sv
// --------------------
// AW issue control and W beat steering
// Each offered AW pushes its port index into a route FIFO once, and W beats
// are taken from the port at the FIFO head until its last beat
// --------------------
`timescale 1ns/1ns
`include "axi_mux_defines.svh"

module mux_w_route (
  input  logic                                          clk_i,
  input  logic                                          reset_i,
  input  logic                                          arb_valid_i,
  input  axi_mux_pkg::mst_id_t                          arb_id_i,
  input  axi_mux_pkg::addr_t                            arb_addr_i,
  input  axi_mux_pkg::len_t                             arb_len_i,
  input  logic                                          mst_aw_ready_i,
  input  axi_mux_pkg::port_mask_t                       slv_w_valid_i,
  input  axi_mux_pkg::data_t   [`AXI_MUX_NUM_PORTS-1:0] slv_w_data_i,
  input  axi_mux_pkg::port_mask_t                       slv_w_last_i,
  input  logic                                          mst_w_ready_i,
  output logic                                          arb_ready_o,
  output logic                                          mst_aw_valid_o,
  output axi_mux_pkg::mst_id_t                          mst_aw_id_o,
  output axi_mux_pkg::addr_t                            mst_aw_addr_o,
  output axi_mux_pkg::len_t                             mst_aw_len_o,
  output axi_mux_pkg::port_mask_t                       slv_w_ready_o,
  output logic                                          mst_w_valid_o,
  output axi_mux_pkg::data_t                            mst_w_data_o,
  output logic                                          mst_w_last_o
);
  import axi_mux_pkg::*;

  localparam int unsigned DEPTH = `AXI_MUX_MAX_W_TRANS;
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  aw_lock_e lock_q, lock_d;

  // Route FIFO of port indices, one entry per open burst
  port_idx_t          fifo_mem [DEPTH];
  logic [PTR_W-1:0]   wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0]   count_q;
  logic               fifo_full, fifo_empty;
  logic               fifo_push, fifo_pop;
  port_idx_t          push_idx, head_idx;

  assign fifo_full  = (count_q == CNT_W'(DEPTH));
  assign fifo_empty = (count_q == '0);
  assign push_idx   = arb_id_i[`AXI_MUX_MST_ID_W-1 -: `AXI_MUX_PORT_IDX_W];
  assign head_idx   = fifo_mem[rd_ptr_q];

  // --------------------
  // AW issue
  // --------------------
  assign mst_aw_id_o   = arb_id_i;
  assign mst_aw_addr_o = arb_addr_i;
  assign mst_aw_len_o  = arb_len_i;

  always_comb begin
    lock_d         = lock_q;
    fifo_push      = 1'b0;
    mst_aw_valid_o = 1'b0;
    arb_ready_o    = 1'b0;
    case (lock_q)
      AW_LOCKED: begin
        // Index already pushed, just hold valid until accepted
        mst_aw_valid_o = 1'b1;
        if (mst_aw_ready_i) begin
          arb_ready_o = 1'b1;
          lock_d      = AW_FREE;
        end
      end
      default: begin
        if (arb_valid_i && !fifo_full) begin
          mst_aw_valid_o = 1'b1;
          fifo_push      = 1'b1;
          if (mst_aw_ready_i) begin
            arb_ready_o = 1'b1;
          end else begin
            lock_d = AW_LOCKED;
          end
        end
      end
    endcase
  end

  // --------------------
  // W steering
  // --------------------
  assign mst_w_data_o  = slv_w_data_i[head_idx];
  assign mst_w_last_o  = slv_w_last_i[head_idx];
  assign mst_w_valid_o = !fifo_empty && slv_w_valid_i[head_idx];
  assign fifo_pop      = mst_w_valid_o && mst_w_ready_i && mst_w_last_o;

  // Ports not at the head wait with ready low
  always_comb begin
    slv_w_ready_o = '0;
    if (!fifo_empty) begin
      slv_w_ready_o[head_idx] = mst_w_ready_i;
    end
  end

  // --------------------
  // State and FIFO
  // --------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      lock_q   <= AW_FREE;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      lock_q <= lock_d;
      if (fifo_push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (fifo_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({fifo_push, fifo_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (fifo_push) begin
      fifo_mem[wr_ptr_q] <= push_idx;
    end
  end

endmodule

// File: tests/axi_wr_mux_assert.sv
// --------------------
// Protocol and routing checker for the AXI write multiplexer
// Bound to every axi_wr_mux instance
// Reference queues follow the W burst order and the B responses in flight
// --------------------
`timescale 1ns/1ns
`include "axi_mux_defines.svh"

module axi_wr_mux_assert (
  input logic                                          clk_i,
  input logic                                          reset_i,
  input axi_mux_pkg::port_mask_t                       slv_aw_valid_i,
  input axi_mux_pkg::port_mask_t                       slv_aw_ready_o,
  input axi_mux_pkg::slv_id_t [`AXI_MUX_NUM_PORTS-1:0] slv_aw_id_i,
  input axi_mux_pkg::addr_t   [`AXI_MUX_NUM_PORTS-1:0] slv_aw_addr_i,
  input axi_mux_pkg::len_t    [`AXI_MUX_NUM_PORTS-1:0] slv_aw_len_i,
  input axi_mux_pkg::port_mask_t                       slv_w_ready_o,
  input axi_mux_pkg::port_mask_t                       slv_b_valid_o,
  input axi_mux_pkg::port_mask_t                       slv_b_ready_i,
  input axi_mux_pkg::slv_id_t [`AXI_MUX_NUM_PORTS-1:0] slv_b_id_o,
  input axi_mux_pkg::resp_t   [`AXI_MUX_NUM_PORTS-1:0] slv_b_resp_o,
  input logic                                          mst_aw_valid_o,
  input logic                                          mst_aw_ready_i,
  input axi_mux_pkg::mst_id_t                          mst_aw_id_o,
  input axi_mux_pkg::addr_t                            mst_aw_addr_o,
  input axi_mux_pkg::len_t                             mst_aw_len_o,
  input logic                                          mst_w_valid_o,
  input logic                                          mst_w_ready_i,
  input axi_mux_pkg::data_t                            mst_w_data_o,
  input logic                                          mst_w_last_o,
  input logic                                          mst_b_valid_i,
  input logic                                          mst_b_ready_o,
  input axi_mux_pkg::mst_id_t                          mst_b_id_i,
  input axi_mux_pkg::resp_t                            mst_b_resp_i
);
  import axi_mux_pkg::*;

  int unsigned fail_count = 0;

  logic       aw_hs, w_hs, b_in_hs, b_out_hs, aw_new, aw_wait_q;
  port_idx_t  aw_port, w_top, w_head, b_port;
  port_mask_t up_aw_hs, round_q;
  mst_id_t    b_head;
  resp_t      b_head_resp;

  // Reference queues of open W bursts and of B in flight
  port_idx_t  wq_mem [8];
  mst_id_t    bq_mem [8];
  resp_t      bq_resp [8];
  logic [2:0] wq_wp, wq_rp, bq_wp, bq_rp;
  logic [3:0] wq_cnt, bq_cnt;

  assign aw_hs    = mst_aw_valid_o && mst_aw_ready_i;
  assign w_hs     = mst_w_valid_o && mst_w_ready_i;
  assign b_in_hs  = mst_b_valid_i && mst_b_ready_o;
  assign b_out_hs = (slv_b_valid_o & slv_b_ready_i) != '0;
  // A new offer starts each burst, in the same order as the AW handshakes
  assign aw_new   = mst_aw_valid_o && !aw_wait_q;
  assign aw_port  = mst_aw_id_o[`AXI_MUX_MST_ID_W-1 -: `AXI_MUX_PORT_IDX_W];
  assign w_top    = mst_w_data_o[`AXI_MUX_DATA_W-1 -: `AXI_MUX_PORT_IDX_W];
  assign w_head   = wq_mem[wq_rp];
  assign b_head   = bq_mem[bq_rp];
  assign b_head_resp = bq_resp[bq_rp];
  assign b_port   = b_head[`AXI_MUX_MST_ID_W-1 -: `AXI_MUX_PORT_IDX_W];
  assign up_aw_hs = slv_aw_valid_i & slv_aw_ready_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      aw_wait_q <= 1'b0;
      wq_wp     <= '0;
      wq_rp     <= '0;
      wq_cnt    <= '0;
      bq_wp     <= '0;
      bq_rp     <= '0;
      bq_cnt    <= '0;
      round_q   <= '0;
    end else begin
      aw_wait_q <= mst_aw_valid_o && !mst_aw_ready_i;
      if (aw_new) begin
        wq_mem[wq_wp] <= aw_port;
        wq_wp         <= wq_wp + 3'd1;
      end
      if (w_hs && mst_w_last_o) begin
        wq_rp <= wq_rp + 3'd1;
      end
      wq_cnt <= wq_cnt + {3'd0, aw_new} - {3'd0, w_hs && mst_w_last_o};
      if (b_in_hs) begin
        bq_mem[bq_wp]  <= mst_b_id_i;
        bq_resp[bq_wp] <= mst_b_resp_i;
        bq_wp          <= bq_wp + 3'd1;
      end
      if (b_out_hs) begin
        bq_rp <= bq_rp + 3'd1;
      end
      bq_cnt <= bq_cnt + {3'd0, b_in_hs} - {3'd0, b_out_hs};
      // Grants seen in the current round of full contention
      if (slv_aw_valid_i != '1) begin
        round_q <= '0;
      end else if (up_aw_hs != '0) begin
        round_q <= ((round_q | up_aw_hs) == '1) ? '0 : (round_q | up_aw_hs);
      end
    end
  end

  // --------------------
  // Reset and AW
  // --------------------
  a_reset: assert property (@(posedge clk_i)
    ($past(reset_i) && !reset_i) |->
      (!mst_aw_valid_o && !mst_w_valid_o && slv_b_valid_o == '0))
    else begin
      $error("Outputs not idle in the first cycle after reset");
      fail_count++;
    end

  a_aw_grant: assert property (@(posedge clk_i) disable iff (reset_i)
    aw_hs |-> slv_aw_ready_o == port_mask_t'(1 << aw_port))
    else begin
      $error("Error slv_aw_ready_o: got %h expected %h", $sampled(slv_aw_ready_o),
             port_mask_t'(1 << $sampled(aw_port)));
      fail_count++;
    end

  a_aw_id: assert property (@(posedge clk_i) disable iff (reset_i)
    aw_hs |-> slv_aw_id_i[aw_port] == mst_aw_id_o[`AXI_MUX_SLV_ID_W-1:0])
    else begin
      $error("Error mst_aw_id_o: got %h upstream id %h", $sampled(mst_aw_id_o),
             $sampled(slv_aw_id_i[aw_port]));
      fail_count++;
    end

  a_aw_payload: assert property (@(posedge clk_i) disable iff (reset_i)
    aw_hs |-> (slv_aw_addr_i[aw_port] == mst_aw_addr_o &&
               slv_aw_len_i[aw_port] == mst_aw_len_o))
    else begin
      $error("Error mst_aw_addr_o/mst_aw_len_o: got %h/%h",
             $sampled(mst_aw_addr_o), $sampled(mst_aw_len_o));
      fail_count++;
    end

  a_aw_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    (mst_aw_valid_o && !mst_aw_ready_i) |=>
      (mst_aw_valid_o && $stable(mst_aw_id_o) && $stable(mst_aw_addr_o) &&
       $stable(mst_aw_len_o)))
    else begin
      $error("Stalled AW dropped or changed before acceptance");
      fail_count++;
    end

  a_aw_fair: assert property (@(posedge clk_i) disable iff (reset_i)
    (slv_aw_valid_i == '1 && up_aw_hs != '0) |-> (round_q & up_aw_hs) == '0)
    else begin
      $error("Error slv_aw_ready_o: second grant %h within round %h",
             $sampled(up_aw_hs), $sampled(round_q));
      fail_count++;
    end

  // --------------------
  // W and B
  // --------------------
  a_w_order: assert property (@(posedge clk_i) disable iff (reset_i)
    w_hs |-> (wq_cnt != '0 && w_top == w_head))
    else begin
      $error("Error mst_w_data_o: port bits %h expected %h", $sampled(w_top),
             $sampled(w_head));
      fail_count++;
    end

  // Only the port owning the oldest open burst sees the downstream ready
  a_w_ready: assert property (@(posedge clk_i) disable iff (reset_i)
    slv_w_ready_o != '0 |->
      (mst_w_ready_i && wq_cnt != '0 && slv_w_ready_o == port_mask_t'(1 << w_head)))
    else begin
      $error("Error slv_w_ready_o: got %h expected %h", $sampled(slv_w_ready_o),
             port_mask_t'(1 << $sampled(w_head)));
      fail_count++;
    end

  a_b_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
    slv_b_valid_o != '0 |-> $onehot(slv_b_valid_o))
    else begin
      $error("Error slv_b_valid_o: %h is not one-hot", $sampled(slv_b_valid_o));
      fail_count++;
    end

  a_b_port: assert property (@(posedge clk_i) disable iff (reset_i)
    slv_b_valid_o != '0 |-> (bq_cnt != '0 && slv_b_valid_o == port_mask_t'(1 << b_port)))
    else begin
      $error("Error slv_b_valid_o: got %h expected %h", $sampled(slv_b_valid_o),
             port_mask_t'(1 << $sampled(b_port)));
      fail_count++;
    end

  a_b_id: assert property (@(posedge clk_i) disable iff (reset_i)
    slv_b_valid_o != '0 |-> slv_b_id_o[b_port] == b_head[`AXI_MUX_SLV_ID_W-1:0])
    else begin
      $error("Error slv_b_id_o: got %h expected %h", $sampled(slv_b_id_o[b_port]),
             $sampled(b_head[`AXI_MUX_SLV_ID_W-1:0]));
      fail_count++;
    end

  a_b_resp: assert property (@(posedge clk_i) disable iff (reset_i)
    slv_b_valid_o != '0 |-> slv_b_resp_o[b_port] == b_head_resp)
    else begin
      $error("Error slv_b_resp_o: got %h expected %h", $sampled(slv_b_resp_o[b_port]),
             $sampled(b_head_resp));
      fail_count++;
    end

endmodule

bind axi_wr_mux axi_wr_mux_assert u_chk (.*);

// File: tests/tb_axi_wr_mux.sv
// --------------------
// Testbench of the AXI write multiplexer
// Random masters drive the upstream ports against a downstream slave model
// Checks live in the bound checker
// --------------------
`timescale 1ns/1ns
`include "axi_mux_defines.svh"

module tb_axi_wr_mux;
  import axi_mux_pkg::*;

  localparam int NP           = `AXI_MUX_NUM_PORTS;
  localparam int RESET_CYCLES = 2;
  localparam int RAND_CYCLES  = 600;
  localparam int FAIR_CYCLES  = 300;
  localparam int DRAIN_CYCLES = 400;
  localparam int LIMIT = 4 * (RESET_CYCLES + 1 + RAND_CYCLES + FAIR_CYCLES + DRAIN_CYCLES);

  logic clk_i = 1'b0;
  logic reset_i;
  port_mask_t            slv_aw_valid_i, slv_aw_ready_o;
  slv_id_t    [NP-1:0]   slv_aw_id_i;
  addr_t      [NP-1:0]   slv_aw_addr_i;
  len_t       [NP-1:0]   slv_aw_len_i;
  port_mask_t            slv_w_valid_i, slv_w_ready_o, slv_w_last_i;
  data_t      [NP-1:0]   slv_w_data_i;
  port_mask_t            slv_b_valid_o, slv_b_ready_i;
  slv_id_t    [NP-1:0]   slv_b_id_o;
  resp_t      [NP-1:0]   slv_b_resp_o;
  logic mst_aw_valid_o, mst_aw_ready_i;
  mst_id_t mst_aw_id_o;
  addr_t   mst_aw_addr_o;
  len_t    mst_aw_len_o;
  logic mst_w_valid_o, mst_w_ready_i, mst_w_last_o;
  data_t   mst_w_data_o;
  logic mst_b_valid_i, mst_b_ready_o;
  mst_id_t mst_b_id_i;
  resp_t   mst_b_resp_i;

  axi_wr_mux DUT (.*);

  always #20 clk_i = ~clk_i;

  logic [31:0] rng_state = 32'hefe0_5a47;
  int          cycle_count = 0;
  int          tb_errors = 0;
  int          aw_accepted = 0;
  int          b_received = 0;

  // Accepted bursts per master that still owe W beats
  len_t        w_pend [NP][$];
  len_t        w_beat [NP];
  logic [13:0] burst_cnt [NP];
  // Slave side
  mst_id_t     sl_aw_q [$];
  mst_id_t     sl_b_id [$];
  resp_t       sl_b_resp [$];

  // Handshakes seen just before the coming rising edge
  port_mask_t  hs_aw_up, hs_w_up, hs_b_up;
  logic        hs_maw, hs_mw_last, hs_mb;
  mst_id_t     hs_maw_id;

  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  task automatic apply_handshakes();
    for (int i = 0; i < NP; i++) begin
      if (hs_aw_up[i]) begin
        w_pend[i].push_back(slv_aw_len_i[i]);
        slv_aw_valid_i[i] = 1'b0;
        aw_accepted++;
      end
      if (hs_w_up[i]) begin
        if (slv_w_last_i[i]) begin
          void'(w_pend[i].pop_front());
          w_beat[i]    = '0;
          burst_cnt[i] = burst_cnt[i] + 14'd1;
        end else begin
          w_beat[i] = w_beat[i] + 8'd1;
        end
      end
      if (hs_b_up[i]) begin
        b_received++;
      end
    end
    if (hs_maw) begin
      sl_aw_q.push_back(hs_maw_id);
    end
    // Slave answers each burst after its last beat
    if (hs_mw_last) begin
      sl_b_id.push_back(sl_aw_q.pop_front());
      sl_b_resp.push_back(resp_t'(next_rand() & 32'h3));
    end
    if (hs_mb) begin
      void'(sl_b_id.pop_front());
      void'(sl_b_resp.pop_front());
    end
  endtask

  task automatic drive_inputs(input logic allow_aw, input logic force_aw);
    logic [31:0] r;
    for (int i = 0; i < NP; i++) begin
      r = next_rand();
      if (!slv_aw_valid_i[i] && allow_aw && (force_aw || r[17:16] == 2'b00)) begin
        slv_aw_valid_i[i] = 1'b1;
        slv_aw_id_i[i]    = slv_id_t'(r & 32'h3);
        slv_aw_addr_i[i]  = addr_t'(next_rand() >> 8);
        slv_aw_len_i[i]   = len_t'(next_rand() & 32'h3);
      end
      if (w_pend[i].size() > 0) begin
        slv_w_valid_i[i] = 1'b1;
        slv_w_data_i[i]  = {port_idx_t'(i), burst_cnt[i]};
        slv_w_last_i[i]  = (w_beat[i] == w_pend[i][0]);
      end else begin
        slv_w_valid_i[i] = 1'b0;
        slv_w_last_i[i]  = 1'b0;
      end
      r = next_rand();
      slv_b_ready_i[i] = (r[19:18] != 2'b00);
    end
    r = next_rand();
    mst_aw_ready_i = r[20];
    mst_w_ready_i  = (r[23:22] != 2'b00);
    mst_b_valid_i  = (sl_b_id.size() > 0);
    if (sl_b_id.size() > 0) begin
      mst_b_id_i   = sl_b_id[0];
      mst_b_resp_i = sl_b_resp[0];
    end
  endtask

  task automatic sample_handshakes();
    hs_aw_up   = slv_aw_valid_i & slv_aw_ready_o;
    hs_w_up    = slv_w_valid_i & slv_w_ready_o;
    hs_b_up    = slv_b_valid_o & slv_b_ready_i;
    hs_maw     = mst_aw_valid_o && mst_aw_ready_i;
    hs_maw_id  = mst_aw_id_o;
    hs_mw_last = mst_w_valid_o && mst_w_ready_i && mst_w_last_o;
    hs_mb      = mst_b_valid_i && mst_b_ready_o;
  endtask

  task automatic run_cycle(input logic allow_aw, input logic force_aw);
    @(negedge clk_i);
    apply_handshakes();
    drive_inputs(allow_aw, force_aw);
    #1;
    sample_handshakes();
  endtask

  function automatic logic traffic_done();
    logic done;
    done = (slv_aw_valid_i == '0) && (sl_aw_q.size() == 0) && (sl_b_id.size() == 0) &&
           (b_received == aw_accepted);
    for (int i = 0; i < NP; i++) begin
      if (w_pend[i].size() > 0) begin
        done = 1'b0;
      end
    end
    return done;
  endfunction

  task automatic report_phase(input string name, input int unsigned base);
    $display("test %s: %0d assertion failures", name, DUT.u_chk.fail_count - base);
  endtask

  // Run limit
  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= LIMIT) begin
      $display("Run stopped by timeout after %0d cycles", cycle_count);
      $display("TESTS FAILED");
      $finish;
    end
  end

  initial begin
    int unsigned base;
    int          n;
    reset_i        = 1'b1;
    slv_aw_valid_i = '0;
    slv_aw_id_i    = '0;
    slv_aw_addr_i  = '0;
    slv_aw_len_i   = '0;
    slv_w_valid_i  = '0;
    slv_w_data_i   = '0;
    slv_w_last_i   = '0;
    slv_b_ready_i  = '0;
    mst_aw_ready_i = 1'b0;
    mst_w_ready_i  = 1'b0;
    mst_b_valid_i  = 1'b0;
    mst_b_id_i     = '0;
    mst_b_resp_i   = '0;
    {hs_aw_up, hs_w_up, hs_b_up} = '0;
    {hs_maw, hs_mw_last, hs_mb}  = '0;
    hs_maw_id = '0;
    for (int i = 0; i < NP; i++) begin
      w_beat[i]    = '0;
      burst_cnt[i] = '0;
    end

    repeat (RESET_CYCLES) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    // Idle edge where the reset outputs are checked
    @(posedge clk_i);
    #1;
    report_phase("reset", 0);

    base = DUT.u_chk.fail_count;
    repeat (RAND_CYCLES) run_cycle(1'b1, 1'b0);
    report_phase("random traffic", base);

    base = DUT.u_chk.fail_count;
    repeat (FAIR_CYCLES) run_cycle(1'b1, 1'b1);
    report_phase("full contention", base);

    base = DUT.u_chk.fail_count;
    n = 0;
    while (!traffic_done() && n < DRAIN_CYCLES) begin
      run_cycle(1'b0, 1'b0);
      n++;
    end
    if (!traffic_done()) begin
      $display("Drain did not finish, %0d of %0d responses returned", b_received,
               aw_accepted);
      tb_errors++;
    end
    report_phase("drain", base);

    $display("summary: %0d bursts, %0d assertion failures, %0d testbench errors",
             aw_accepted, DUT.u_chk.fail_count, tb_errors);
    if (DUT.u_chk.fail_count == 0 && tb_errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule
